/* source/mmio_cpl_pkg.sv */
// Widths and vector types shared by the MMIO read completion path
// Design files pick these up by import or by scoped name

`default_nettype none

package mmio_cpl_pkg;

    // Largest tag table the design supports
    localparam int MAX_TAGS = 32;

    // Field widths of a completion header
    localparam int TAG_W        = 5;
    localparam int REQ_ID_W     = 16;
    localparam int LOWER_ADDR_W = 7;
    localparam int BYTE_COUNT_W = 12;
    localparam int DW_LEN_W     = 10;

    // Width of the data the accelerator returns for one read
    localparam int PAYLOAD_W = 64;

    // MMIO read tag, which also indexes the request table
    typedef logic [TAG_W-1:0] t_tag;

    // PCIe requester ID, returned unchanged in the completion
    typedef logic [REQ_ID_W-1:0] t_req_id;

    // Low address bits of the request
    typedef logic [LOWER_ADDR_W-1:0] t_lower_addr;

    // Byte count of the read; only 4 and 8 occur in practice
    typedef logic [BYTE_COUNT_W-1:0] t_byte_count;

    // Completion length in dwords
    typedef logic [DW_LEN_W-1:0] t_dw_len;

    // Response data from the accelerator
    typedef logic [PAYLOAD_W-1:0] t_payload;

endpackage

`default_nettype wire

/* source/mmio_cpl_if.sv */
// Bundles between the top level and the completion generator
// mmio_req_if carries host read requests, mmio_rsp_if carries accelerator data

`timescale 1ns/1ps
`default_nettype none

// Host read request; valid is a one-cycle strobe and the sink always accepts
interface mmio_req_if;
    import mmio_cpl_pkg::*;

    logic        valid;
    t_tag        tag;
    t_req_id     requester_id;
    t_lower_addr lower_addr;
    t_byte_count byte_count;

    modport source (output valid, output tag, output requester_id,
                    output lower_addr, output byte_count);

    modport sink (input valid, input tag, input requester_id,
                  input lower_addr, input byte_count);
endinterface

// Accelerator read response with a valid/ready handshake
interface mmio_rsp_if;
    import mmio_cpl_pkg::*;

    logic     valid;
    logic     ready;
    t_tag     tag;
    t_payload payload;

    // The accelerator drives the data, the generator drives ready
    modport source (output valid, output tag, output payload, input ready);

    modport sink (input valid, input tag, input payload, output ready);
endinterface

`default_nettype wire

/* source/mmio_req_table.sv */
// Table of outstanding MMIO read request details, indexed by tag
// One registered write port and one combinational read port

`timescale 1ns/1ps
`default_nettype none

module mmio_req_table #(
    parameter int NUM_TAGS = 16
) (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      wen,
    input  mmio_cpl_pkg::t_tag        waddr,
    input  mmio_cpl_pkg::t_req_id     wreq_id,
    input  mmio_cpl_pkg::t_lower_addr wlower_addr,
    input  mmio_cpl_pkg::t_byte_count wbyte_count,
    input  mmio_cpl_pkg::t_tag        raddr,
    output mmio_cpl_pkg::t_req_id     rreq_id,
    output mmio_cpl_pkg::t_lower_addr rlower_addr,
    output mmio_cpl_pkg::t_byte_count rbyte_count
);
    import mmio_cpl_pkg::*;

    // Index width for the entries in use; at least one bit
    localparam int IDX_W = (NUM_TAGS > 1) ? $clog2(NUM_TAGS) : 1;

    // The tag field cannot address more entries than MAX_TAGS
    if (NUM_TAGS > MAX_TAGS || NUM_TAGS < 1)
    begin : g_bad_depth
        $error("NUM_TAGS must be between 1 and %0d", MAX_TAGS);
    end

    // Distributed memory, one array per field
    t_req_id     mem_req_id     [NUM_TAGS];
    t_lower_addr mem_lower_addr [NUM_TAGS];
    t_byte_count mem_byte_count [NUM_TAGS];

    logic w_in_range;
    logic r_in_range;

    assign w_in_range = int'(waddr) < NUM_TAGS;
    assign r_in_range = int'(raddr) < NUM_TAGS;

    // Writes are ignored during reset so a stray strobe cannot load an entry
    always_ff @(posedge clk)
    begin
        if (reset_n && wen && w_in_range)
        begin
            mem_req_id[waddr[IDX_W-1:0]]     <= wreq_id;
            mem_lower_addr[waddr[IDX_W-1:0]] <= wlower_addr;
            mem_byte_count[waddr[IDX_W-1:0]] <= wbyte_count;
        end
    end

    // An out-of-range tag reads back as zero instead of an undefined entry
    assign rreq_id     = r_in_range ? mem_req_id[raddr[IDX_W-1:0]]     : '0;
    assign rlower_addr = r_in_range ? mem_lower_addr[raddr[IDX_W-1:0]] : '0;
    assign rbyte_count = r_in_range ? mem_byte_count[raddr[IDX_W-1:0]] : '0;

endmodule

`default_nettype wire

/* source/mmio_rsp_fifo.sv */
// Two-entry FIFO holding accelerator responses joined with their request details
// Enqueue and dequeue may happen in the same cycle

`timescale 1ns/1ps
`default_nettype none

module mmio_rsp_fifo (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      enq_en,
    input  mmio_cpl_pkg::t_tag        enq_tag,
    input  mmio_cpl_pkg::t_payload    enq_payload,
    input  mmio_cpl_pkg::t_req_id     enq_req_id,
    input  mmio_cpl_pkg::t_lower_addr enq_lower_addr,
    input  mmio_cpl_pkg::t_byte_count enq_byte_count,
    output logic                      not_full,
    input  logic                      deq_en,
    output logic                      not_empty,
    output mmio_cpl_pkg::t_tag        first_tag,
    output mmio_cpl_pkg::t_payload    first_payload,
    output mmio_cpl_pkg::t_req_id     first_req_id,
    output mmio_cpl_pkg::t_lower_addr first_lower_addr,
    output mmio_cpl_pkg::t_byte_count first_byte_count
);
    import mmio_cpl_pkg::*;

    // Two slots of storage with one array per field
    t_tag        slot_tag        [2];
    t_payload    slot_payload    [2];
    t_req_id     slot_req_id     [2];
    t_lower_addr slot_lower_addr [2];
    t_byte_count slot_byte_count [2];

    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       do_enq;
    logic       do_deq;

    assign not_full  = (count != 2'd2);
    assign not_empty = (count != 2'd0);

    // Requests beyond the flags are dropped rather than corrupting a slot
    assign do_enq = enq_en && not_full;
    assign do_deq = deq_en && not_empty;

    // Pointers and occupancy
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end
        else
        begin
            if (do_enq)
                wr_ptr <= ~wr_ptr;
            if (do_deq)
                rd_ptr <= ~rd_ptr;

            // Simultaneous enqueue and dequeue leaves the count unchanged
            case ({do_enq, do_deq})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    // The slot under the write pointer takes the joined response
    always_ff @(posedge clk)
    begin
        if (do_enq)
        begin
            slot_tag[wr_ptr]        <= enq_tag;
            slot_payload[wr_ptr]    <= enq_payload;
            slot_req_id[wr_ptr]     <= enq_req_id;
            slot_lower_addr[wr_ptr] <= enq_lower_addr;
            slot_byte_count[wr_ptr] <= enq_byte_count;
        end
    end

    // Head of the queue
    assign first_tag        = slot_tag[rd_ptr];
    assign first_payload    = slot_payload[rd_ptr];
    assign first_req_id     = slot_req_id[rd_ptr];
    assign first_lower_addr = slot_lower_addr[rd_ptr];
    assign first_byte_count = slot_byte_count[rd_ptr];

endmodule

`default_nettype wire

/* source/mmio_cpl_gen.sv */
// Completion generator for host MMIO reads
// Records requests by tag, joins accelerator data to them and drives completions

`timescale 1ns/1ps
`default_nettype none

module mmio_cpl_gen #(
    parameter int NUM_TAGS = 16
) (
    input  logic                      clk,
    input  logic                      reset_n,
    mmio_req_if.sink                  req,
    mmio_rsp_if.sink                  rsp,
    output logic                      cpl_valid,
    input  logic                      cpl_ready,
    output mmio_cpl_pkg::t_tag        cpl_tag,
    output mmio_cpl_pkg::t_req_id     cpl_requester_id,
    output mmio_cpl_pkg::t_lower_addr cpl_lower_addr,
    output mmio_cpl_pkg::t_byte_count cpl_byte_count,
    output mmio_cpl_pkg::t_dw_len     cpl_length,
    output mmio_cpl_pkg::t_payload    cpl_payload
);
    import mmio_cpl_pkg::*;

    // Registered copy of the incoming request
    logic        req_valid_q;
    t_tag        req_tag_q;
    t_req_id     req_id_q;
    t_lower_addr req_lower_addr_q;
    t_byte_count req_byte_count_q;

    // Details looked up for the response currently on the bus
    t_req_id     rsp_req_id;
    t_lower_addr rsp_lower_addr;
    t_byte_count rsp_byte_count;

    // FIFO head and control
    logic        fifo_not_full;
    logic        fifo_not_empty;
    logic        fifo_enq;
    logic        fifo_deq;
    logic        out_load;
    t_tag        head_tag;
    t_payload    head_payload;
    t_req_id     head_req_id;
    t_lower_addr head_lower_addr;
    t_byte_count head_byte_count;

    // The strobe is registered first and the table written one edge later
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            req_valid_q <= 1'b0;
        else
            req_valid_q <= req.valid;
    end

    // Detail registers follow the strobe and carry no reset
    always_ff @(posedge clk)
    begin
        if (req.valid)
        begin
            req_tag_q        <= req.tag;
            req_id_q         <= req.requester_id;
            req_lower_addr_q <= req.lower_addr;
            req_byte_count_q <= req.byte_count;
        end
    end

    mmio_req_table #(
        .NUM_TAGS (NUM_TAGS)
    ) u_req_table (
        .clk         (clk),
        .reset_n     (reset_n),
        .wen         (req_valid_q),
        .waddr       (req_tag_q),
        .wreq_id     (req_id_q),
        .wlower_addr (req_lower_addr_q),
        .wbyte_count (req_byte_count_q),
        .raddr       (rsp.tag),
        .rreq_id     (rsp_req_id),
        .rlower_addr (rsp_lower_addr),
        .rbyte_count (rsp_byte_count)
    );

    // Responses are accepted whenever the FIFO has room
    assign rsp.ready = fifo_not_full;
    assign fifo_enq  = rsp.valid && fifo_not_full;

    mmio_rsp_fifo u_rsp_fifo (
        .clk              (clk),
        .reset_n          (reset_n),
        .enq_en           (fifo_enq),
        .enq_tag          (rsp.tag),
        .enq_payload      (rsp.payload),
        .enq_req_id       (rsp_req_id),
        .enq_lower_addr   (rsp_lower_addr),
        .enq_byte_count   (rsp_byte_count),
        .not_full         (fifo_not_full),
        .deq_en           (fifo_deq),
        .not_empty        (fifo_not_empty),
        .first_tag        (head_tag),
        .first_payload    (head_payload),
        .first_req_id     (head_req_id),
        .first_lower_addr (head_lower_addr),
        .first_byte_count (head_byte_count)
    );

    // The output register can take a new beat when it is empty or draining
    assign out_load = cpl_ready || !cpl_valid;
    assign fifo_deq = fifo_not_empty && out_load;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            cpl_valid <= 1'b0;
        else if (out_load)
            cpl_valid <= fifo_not_empty;
    end

    // Fields hold steady while a beat is stalled
    always_ff @(posedge clk)
    begin
        if (fifo_deq)
        begin
            cpl_tag          <= head_tag;
            cpl_payload      <= head_payload;
            cpl_requester_id <= head_req_id;
            cpl_lower_addr   <= head_lower_addr;
            cpl_byte_count   <= head_byte_count;
            // Length in dwords is the byte count divided by four
            cpl_length       <= t_dw_len'(head_byte_count[BYTE_COUNT_W-1:2]);
        end
    end

endmodule

`default_nettype wire

/* source/mmio_cpl_top.sv */
// Top level of the MMIO read completion path
// Maps plain request, response and completion ports onto the generator

`timescale 1ns/1ps
`default_nettype none

module mmio_cpl_top #(
    parameter int NUM_TAGS = 16
) (
    input  logic                      clk,
    input  logic                      reset_n,

    // Host read requests, one-cycle strobe
    input  logic                      req_valid,
    input  mmio_cpl_pkg::t_tag        req_tag,
    input  mmio_cpl_pkg::t_req_id     req_requester_id,
    input  mmio_cpl_pkg::t_lower_addr req_lower_addr,
    input  mmio_cpl_pkg::t_byte_count req_byte_count,

    // Accelerator read data
    input  logic                      rsp_valid,
    output logic                      rsp_ready,
    input  mmio_cpl_pkg::t_tag        rsp_tag,
    input  mmio_cpl_pkg::t_payload    rsp_payload,

    // Completions with data
    output logic                      cpl_valid,
    input  logic                      cpl_ready,
    output mmio_cpl_pkg::t_tag        cpl_tag,
    output mmio_cpl_pkg::t_req_id     cpl_requester_id,
    output mmio_cpl_pkg::t_lower_addr cpl_lower_addr,
    output mmio_cpl_pkg::t_byte_count cpl_byte_count,
    output mmio_cpl_pkg::t_dw_len     cpl_length,
    output mmio_cpl_pkg::t_payload    cpl_payload
);

    mmio_req_if req_bus ();
    mmio_rsp_if rsp_bus ();

    // The top level plays the source side of both bundles
    assign req_bus.valid        = req_valid;
    assign req_bus.tag          = req_tag;
    assign req_bus.requester_id = req_requester_id;
    assign req_bus.lower_addr   = req_lower_addr;
    assign req_bus.byte_count   = req_byte_count;

    assign rsp_bus.valid   = rsp_valid;
    assign rsp_bus.tag     = rsp_tag;
    assign rsp_bus.payload = rsp_payload;
    assign rsp_ready       = rsp_bus.ready;

    mmio_cpl_gen #(
        .NUM_TAGS (NUM_TAGS)
    ) u_cpl_gen (
        .clk              (clk),
        .reset_n          (reset_n),
        .req              (req_bus.sink),
        .rsp              (rsp_bus.sink),
        .cpl_valid        (cpl_valid),
        .cpl_ready        (cpl_ready),
        .cpl_tag          (cpl_tag),
        .cpl_requester_id (cpl_requester_id),
        .cpl_lower_addr   (cpl_lower_addr),
        .cpl_byte_count   (cpl_byte_count),
        .cpl_length       (cpl_length),
        .cpl_payload      (cpl_payload)
    );

endmodule

`default_nettype wire

/* verification/mmio_cpl_sva.sv */
// Protocol assertions for the completion generator
// Bound into mmio_cpl_gen, tracking each tag from request to completion

`timescale 1ns/1ps
`default_nettype none

module mmio_cpl_sva #(
    parameter int NUM_TAGS = 16
) (
    input logic                      clk,
    input logic                      reset_n,
    input logic                      req_valid,
    input mmio_cpl_pkg::t_tag        req_tag,
    input logic                      rsp_valid,
    input logic                      rsp_ready,
    input mmio_cpl_pkg::t_tag        rsp_tag,
    input logic                      cpl_valid,
    input logic                      cpl_ready,
    input mmio_cpl_pkg::t_tag        cpl_tag,
    input mmio_cpl_pkg::t_req_id     cpl_requester_id,
    input mmio_cpl_pkg::t_lower_addr cpl_lower_addr,
    input mmio_cpl_pkg::t_byte_count cpl_byte_count,
    input mmio_cpl_pkg::t_dw_len     cpl_length,
    input mmio_cpl_pkg::t_payload    cpl_payload
);
    import mmio_cpl_pkg::*;

    // One bit per tag, set by a request and cleared when its completion leaves
    logic [MAX_TAGS-1:0] active;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            active <= '0;
        else
        begin
            if (cpl_valid && cpl_ready)
                active[cpl_tag] <= 1'b0;
            if (req_valid)
                active[req_tag] <= 1'b1;
        end
    end

    req_tag_free: assert property (@(posedge clk) disable iff (!reset_n)
        req_valid |-> !active[req_tag])
        else $error("Request for tag %0d while it is still outstanding", req_tag);

    rsp_tag_active: assert property (@(posedge clk) disable iff (!reset_n)
        (rsp_valid && rsp_ready) |-> active[rsp_tag])
        else $error("Response for tag %0d that has no outstanding request", rsp_tag);

    req_tag_range: assert property (@(posedge clk) disable iff (!reset_n)
        req_valid |-> (int'(req_tag) < NUM_TAGS))
        else $error("Request tag %0d is beyond the table", req_tag);

    rsp_tag_range: assert property (@(posedge clk) disable iff (!reset_n)
        rsp_valid |-> (int'(rsp_tag) < NUM_TAGS))
        else $error("Response tag %0d is beyond the table", rsp_tag);

    // A stalled beat keeps valid and every field until it is taken
    cpl_hold: assert property (@(posedge clk) disable iff (!reset_n)
        (cpl_valid && !cpl_ready) |=> (cpl_valid && $stable(cpl_tag)
            && $stable(cpl_requester_id) && $stable(cpl_lower_addr)
            && $stable(cpl_byte_count) && $stable(cpl_length) && $stable(cpl_payload)))
        else $error("Completion output changed while stalled");

endmodule

bind mmio_cpl_gen mmio_cpl_sva #(
    .NUM_TAGS (NUM_TAGS)
) u_sva (
    .clk              (clk),
    .reset_n          (reset_n),
    .req_valid        (req.valid),
    .req_tag          (req.tag),
    .rsp_valid        (rsp.valid),
    .rsp_ready        (rsp.ready),
    .rsp_tag          (rsp.tag),
    .cpl_valid        (cpl_valid),
    .cpl_ready        (cpl_ready),
    .cpl_tag          (cpl_tag),
    .cpl_requester_id (cpl_requester_id),
    .cpl_lower_addr   (cpl_lower_addr),
    .cpl_byte_count   (cpl_byte_count),
    .cpl_length       (cpl_length),
    .cpl_payload      (cpl_payload)
);

`default_nettype wire

/* verification/tb_mmio_cpl.sv */
// Table-driven testbench for the MMIO read completion path
// Sends request batches, answers them out of order and checks every completion

`timescale 1ns/1ps
`default_nettype none

module tb_mmio_cpl;
    import mmio_cpl_pkg::*;

    localparam int NUM_TAGS    = 16;
    localparam int NUM_ENTRIES = 16;
    localparam int BATCH       = 4;
    localparam int DRIVE_DLY   = 2;

    // One read with its request details and the data returned for it
    typedef struct packed {
        t_tag        tag;
        t_req_id     req_id;
        t_lower_addr lower_addr;
        t_byte_count byte_count;
        t_payload    payload;
    } stim_t;

    logic        clk = 1'b0;
    logic        reset_n;
    logic        req_valid;
    t_tag        req_tag;
    t_req_id     req_requester_id;
    t_lower_addr req_lower_addr;
    t_byte_count req_byte_count;
    logic        rsp_valid;
    logic        rsp_ready;
    t_tag        rsp_tag;
    t_payload    rsp_payload;
    logic        cpl_valid;
    logic        cpl_ready;
    t_tag        cpl_tag;
    t_req_id     cpl_requester_id;
    t_lower_addr cpl_lower_addr;
    t_byte_count cpl_byte_count;
    t_dw_len     cpl_length;
    t_payload    cpl_payload;

    // Batches of four; the last batch reuses the tags of the first with new details
    stim_t stim [NUM_ENTRIES] = '{
        '{5'd3,  16'h0a01, 7'h04, 12'd4, 64'h0123_4567_89ab_cdef},
        '{5'd7,  16'h0a02, 7'h10, 12'd8, 64'hfedc_ba98_7654_3210},
        '{5'd12, 16'h0b03, 7'h28, 12'd4, 64'h0000_0000_dead_beef},
        '{5'd0,  16'h0b04, 7'h7c, 12'd8, 64'hcafe_f00d_1234_5678},
        '{5'd1,  16'h1105, 7'h00, 12'd8, 64'h1111_2222_3333_4444},
        '{5'd9,  16'h1106, 7'h44, 12'd4, 64'h5555_6666_7777_8888},
        '{5'd15, 16'h2207, 7'h18, 12'd8, 64'h9999_aaaa_bbbb_cccc},
        '{5'd4,  16'h2208, 7'h3c, 12'd4, 64'hdddd_eeee_ffff_0000},
        '{5'd2,  16'h3309, 7'h08, 12'd4, 64'h0f0f_0f0f_f0f0_f0f0},
        '{5'd5,  16'h330a, 7'h50, 12'd8, 64'h8000_0000_0000_0001},
        '{5'd11, 16'h440b, 7'h60, 12'd8, 64'h7fff_ffff_ffff_fffe},
        '{5'd14, 16'h440c, 7'h0c, 12'd4, 64'h0246_8ace_1357_9bdf},
        '{5'd7,  16'h550d, 7'h20, 12'd4, 64'ha5a5_a5a5_5a5a_5a5a},
        '{5'd3,  16'h550e, 7'h74, 12'd8, 64'h3c3c_3c3c_c3c3_c3c3},
        '{5'd0,  16'h660f, 7'h34, 12'd4, 64'h0102_0304_0506_0708},
        '{5'd12, 16'h6610, 7'h48, 12'd8, 64'h1020_3040_5060_7080}
    };

    // Responses go out in this order of entry indices, permuted within each batch
    int rsp_seq [NUM_ENTRIES] = '{2, 0, 3, 1, 5, 7, 4, 6, 9, 8, 11, 10, 15, 13, 12, 14};

    int          cur_entry [MAX_TAGS];
    t_tag        tag_q [$];
    logic [31:0] lfsr = 32'd32;
    logic        rand_ready = 1'b0;
    logic        prev_rsp_ready = 1'b1;
    logic        prev_stalled = 1'b0;
    int          cpl_count = 0;
    int          err_count = 0;
    int          check_count = 0;

    mmio_cpl_top #(.NUM_TAGS(NUM_TAGS)) UUT (.*);

    always #20 clk = ~clk;

    // Galois LFSR with the polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0])
            next = next ^ 32'h8020_0003;
        return next;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        assert (got === exp)
        else
        begin
            err_count++;
            $display("Error at time %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic send_request(input int idx);
        req_valid                = 1'b1;
        req_tag                  = stim[idx].tag;
        req_requester_id         = stim[idx].req_id;
        req_lower_addr           = stim[idx].lower_addr;
        req_byte_count           = stim[idx].byte_count;
        cur_entry[stim[idx].tag] = idx;
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // With lat_check set, the completion must be up one cycle after the handshake
    task automatic send_response(input int idx, input bit lat_check);
        rsp_valid   = 1'b1;
        rsp_tag     = stim[idx].tag;
        rsp_payload = stim[idx].payload;
        @(posedge clk);
        while (!rsp_ready)
            @(posedge clk);
        #DRIVE_DLY;
        rsp_valid = 1'b0;
        if (lat_check)
        begin
            @(posedge clk);
            #DRIVE_DLY;
            check_value("cpl_valid", 64'(cpl_valid), 64'd1);
            check_value("cpl_tag", 64'(cpl_tag), 64'(stim[idx].tag));
        end
    endtask

    task automatic wait_drain(input int target);
        do
        begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        while (cpl_count < target);
    endtask

    // Back-pressure is random once enabled and otherwise always ready
    always @(posedge clk)
    begin
        #1;
        if (rand_ready)
        begin
            lfsr      = lfsr_step(lfsr);
            cpl_ready = lfsr[0];
        end
        else
            cpl_ready = 1'b1;
    end

    // Accepted responses queue up in order and completions must leave in that order
    always @(posedge clk)
    begin : completion_monitor
        t_tag exp_tag;
        int   idx;
        if (reset_n)
        begin
            if (rsp_valid && rsp_ready)
                tag_q.push_back(rsp_tag);
            if (cpl_valid && cpl_ready)
            begin
                cpl_count++;
                assert (tag_q.size() > 0)
                else
                begin
                    err_count++;
                    $display("Completion for tag %0d at time %0t has no accepted response",
                             cpl_tag, $time);
                end
                if (tag_q.size() > 0)
                begin
                    exp_tag = tag_q.pop_front();
                    idx     = cur_entry[exp_tag];
                    check_value("cpl_tag", 64'(cpl_tag), 64'(exp_tag));
                    check_value("cpl_payload", cpl_payload, stim[idx].payload);
                    check_value("cpl_requester_id", 64'(cpl_requester_id),
                                64'(stim[idx].req_id));
                    check_value("cpl_lower_addr", 64'(cpl_lower_addr),
                                64'(stim[idx].lower_addr));
                    check_value("cpl_byte_count", 64'(cpl_byte_count),
                                64'(stim[idx].byte_count));
                    check_value("cpl_length", 64'(cpl_length), 64'(stim[idx].byte_count / 4));
                end
            end
            // A full FIFO needs an edge on which the output stage held its beat
            assert (!(prev_rsp_ready && !rsp_ready) || prev_stalled)
            else
            begin
                err_count++;
                $display("rsp_ready fell at time %0t without a stalled completion", $time);
            end
            prev_rsp_ready = rsp_ready;
            prev_stalled   = cpl_valid && !cpl_ready;
        end
    end

    initial
    begin : watchdog
        repeat (NUM_ENTRIES * 50) @(posedge clk);
        $display("Timeout: completions did not drain within %0d cycles", NUM_ENTRIES * 50);
        $display("Checks: %0d, errors: %0d", check_count, err_count);
        $display("sim failed");
        $finish;
    end

    initial
    begin : main
        int b;
        int k;
        reset_n          = 1'b0;
        req_valid        = 1'b0;
        req_tag          = '0;
        req_requester_id = '0;
        req_lower_addr   = '0;
        req_byte_count   = '0;
        rsp_valid        = 1'b0;
        rsp_tag          = '0;
        rsp_payload      = '0;
        cpl_ready        = 1'b0;
        repeat (16) @(posedge clk);
        #DRIVE_DLY;
        reset_n = 1'b1;
        check_value("cpl_valid", 64'(cpl_valid), 64'd0);
        check_value("rsp_ready", 64'(rsp_ready), 64'd1);

        // The first batch runs without back-pressure and checks the latency
        for (b = 0; b < NUM_ENTRIES / BATCH; b++)
        begin
            rand_ready = (b != 0);
            for (k = 0; k < BATCH; k++)
                send_request(b * BATCH + k);
            req_valid = 1'b0;
            repeat (2) @(posedge clk);
            #DRIVE_DLY;
            for (k = 0; k < BATCH; k++)
                send_response(rsp_seq[b * BATCH + k], b == 0);
            wait_drain((b + 1) * BATCH);
        end

        // Idle cycles after the last drain expose any duplicated completion
        repeat (4) @(posedge clk);
        #DRIVE_DLY;
        check_value("completion count", 64'(cpl_count), 64'(NUM_ENTRIES));
        check_value("pending responses", 64'(tag_q.size()), 64'd0);
        check_value("cpl_valid", 64'(cpl_valid), 64'd0);
        check_value("rsp_ready", 64'(rsp_ready), 64'd1);
        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
source/mmio_cpl_pkg.sv
source/mmio_cpl_if.sv
source/mmio_req_table.sv
source/mmio_rsp_fifo.sv
source/mmio_cpl_gen.sv
source/mmio_cpl_top.sv
verification/mmio_cpl_sva.sv
verification/tb_mmio_cpl.sv

/* Makefile */
TOP := tb_mmio_cpl

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
